//--- build.f
src/jpeg_huff_pkg.sv
src/dht_tbl_if.sv
src/dht_parser.sv
src/dht_table_store.sv
src/dht_lookup.sv
src/jpeg_dht.sv
verif/jpeg_dht_sva.sv
verif/tb_jpeg_dht.sv

//--- run.sh
#!/usr/bin/env bash
set -e
set -o pipefail
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module tb_jpeg_dht -f build.f -o tb_jpeg_dht
./obj_dir/tb_jpeg_dht | tee sim.log
if grep -q "TEST FAILED" sim.log; then
    exit 1
fi

//--- verif/tb_jpeg_dht.sv
// Testbench for the DHT loader, loads segments and checks lookups against a canonical model
`timescale 1ns/100ps

module tb_jpeg_dht;

    localparam int CLK_PERIOD = 8;
    localparam int NUM_SPEC   = 6;
    localparam int NUM_SEG    = 3;
    localparam int NUM_RAND   = 12;

    logic        clk_i = 1'b0;
    logic        rst_i;
    logic        cfg_valid_i;
    logic [7:0]  cfg_data_i;
    logic        cfg_last_i;
    logic        cfg_accept_o;
    logic        lookup_req_i;
    logic [1:0]  lookup_table_i;
    logic [15:0] lookup_input_i;
    logic        lookup_valid_o;
    logic [4:0]  lookup_width_o;
    logic [7:0]  lookup_value_o;

    // ----------------------------------------
    // Table specs, one per loaded table
    // ----------------------------------------

    // Counts per code length, index 0 is length 1
    int spec_cnt [NUM_SPEC][16] = '{
        '{0, 2, 0, 3, 0, 0, 2, 0, 0, 1, 0, 0, 0, 0, 0, 0},
        '{0, 2, 0, 3, 0, 0, 2, 0, 0, 1, 0, 0, 0, 0, 0, 0},
        '{0, 1, 5, 1, 1, 1, 1, 1, 1, 0, 0, 0, 0, 0, 0, 0},
        '{1, 0, 3, 0, 3, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 2},
        '{0, 0, 6, 0, 0, 4, 0, 0, 0, 0, 0, 5, 0, 0, 0, 0},
        '{0, 1, 5, 1, 1, 1, 1, 1, 1, 0, 0, 0, 0, 0, 0, 0}
    };
    logic [7:0] spec_id   [NUM_SPEC] = '{8'h00, 8'h00, 8'h10, 8'h01, 8'h11, 8'h10};
    int         spec_seed [NUM_SPEC] = '{1, 6, 2, 3, 4, 5};
    // Segment each spec belongs to, segment 1 holds all four tables
    // and the last spec alone reloads luma AC
    int         spec_seg  [NUM_SPEC] = '{0, 1, 1, 1, 1, 2};

    // Segment bytes with their cfg_last_i flags
    logic [7:0]  stim_byte [$];
    logic        stim_last [$];
    int          stim_seg  [$];
    // Lookup rows
    string       row_name  [$];
    int          row_seg   [$];
    int          row_tbl   [$];
    int unsigned row_win   [$];
    int          row_width [$];
    int          row_value [$];
    // Lookups in flight
    string       exp_name  [$];
    int          exp_width [$];
    int          exp_value [$];

    // Canonical codes of one table
    int unsigned code_tab [256];
    int          len_tab  [256];
    int          sym_tab  [256];
    int          ncode;

    integer      seed = 55;
    bit          built = 1'b0;
    int          n_pass = 0;
    int          n_fail = 0;
    int          stalls = 0;
    logic [1:0]  req_hist = 2'b00;
    string       mon_name;
    int          mon_width;
    int          mon_value;
    int          limit;

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    jpeg_dht jpeg_dht_inst (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .cfg_valid_i    (cfg_valid_i),
        .cfg_data_i     (cfg_data_i),
        .cfg_last_i     (cfg_last_i),
        .cfg_accept_o   (cfg_accept_o),
        .lookup_req_i   (lookup_req_i),
        .lookup_table_i (lookup_table_i),
        .lookup_input_i (lookup_input_i),
        .lookup_valid_o (lookup_valid_o),
        .lookup_width_o (lookup_width_o),
        .lookup_value_o (lookup_value_o)
    );

    // ----------------------------------------
    // Canonical Huffman model
    // ----------------------------------------
    task automatic build_codes(input int s);
        int unsigned code;
        code  = 0;
        ncode = 0;
        for (int l = 1; l <= 16; l++)
        begin
            for (int i = 0; i < spec_cnt[s][l-1]; i++)
            begin
                code_tab[ncode] = code;
                len_tab[ncode]  = l;
                sym_tab[ncode]  = (spec_seed[s] * 61 + ncode * 7 + 3) % 256;
                ncode++;
                code++;
            end
            code = code << 1;
        end
    endtask

    // Code that prefixes the window, -1 for unused code space
    function automatic int decode(input int unsigned win);
        int hit;
        hit = -1;
        for (int k = ncode - 1; k >= 0; k--)
        begin
            if ((win >> (16 - len_tab[k])) == code_tab[k])
                hit = k;
        end
        return hit;
    endfunction

    task automatic add_row(input string name, input int seg, input int t, input int unsigned win);
        int k;
        k = decode(win);
        if (k >= 0)
        begin
            row_name.push_back(name);
            row_seg.push_back(seg);
            row_tbl.push_back(t);
            row_win.push_back(win);
            row_width.push_back(len_tab[k]);
            row_value.push_back(sym_tab[k]);
        end
    endtask

    // Every code of the current table, low bits random
    task automatic add_all_codes(input int seg, input int t, input string tag);
        int unsigned win;
        for (int k = 0; k < ncode; k++)
        begin
            win = (code_tab[k] << (16 - len_tab[k]))
                | ($unsigned($random(seed)) & ((32'd1 << (16 - len_tab[k])) - 32'd1));
            add_row($sformatf("%s_t%0d_code%0d", tag, t, k), seg, t, win);
        end
    endtask

    task automatic build_segments();
        for (int s = 0; s < NUM_SPEC; s++)
        begin
            build_codes(s);
            stim_byte.push_back(spec_id[s]);
            stim_seg.push_back(spec_seg[s]);
            for (int l = 0; l < 16; l++)
            begin
                stim_byte.push_back(8'(spec_cnt[s][l]));
                stim_seg.push_back(spec_seg[s]);
            end
            for (int k = 0; k < ncode; k++)
            begin
                stim_byte.push_back(8'(sym_tab[k]));
                stim_seg.push_back(spec_seg[s]);
            end
        end
        // Only the final byte of a segment carries cfg_last_i
        for (int i = 0; i < stim_byte.size(); i++)
            stim_last.push_back(i == stim_byte.size() - 1 || stim_seg[i+1] != stim_seg[i]);
    endtask

    task automatic build_rows();
        int unsigned win;
        build_codes(0);
        add_all_codes(0, 0, "gap_load");
        // Table t holds spec t+1 after segment 1
        for (int t = 0; t < 4; t++)
        begin
            build_codes(t + 1);
            add_all_codes(1, t, "multi");
        end
        // Same window against all four tables
        for (int r = 0; r < NUM_RAND; r++)
        begin
            win = $unsigned($random(seed)) & 32'hffff;
            for (int t = 0; t < 4; t++)
            begin
                build_codes(t + 1);
                add_row($sformatf("rand%0d_t%0d", r, t), 1, t, win);
            end
        end
        // Luma AC now holds spec 5
        for (int t = 0; t < 4; t++)
        begin
            build_codes((t == 1) ? 5 : t + 1);
            add_all_codes(2, t, "reload");
        end
    endtask

    // ----------------------------------------
    // Drivers and checks
    // ----------------------------------------
    task automatic check_value(input string name, input int exp, input int act);
        if (exp != act)
        begin
            $display("[FAIL] %s expected %0d actual %0d", name, exp, act);
            n_fail++;
        end
        else
        begin
            $display("[PASS] %s", name);
            n_pass++;
        end
    endtask

    // Called just after a rising edge, returns after the transfer edge
    task automatic send_byte(input logic [7:0] b, input logic last);
        cfg_valid_i <= 1'b1;
        cfg_data_i  <= b;
        cfg_last_i  <= last;
        @(negedge clk_i);
        while (!cfg_accept_o)
        begin
            stalls++;
            @(negedge clk_i);
        end
        @(posedge clk_i);
    endtask

    // Results in request order, two cycles after each request
    always @(negedge clk_i)
    begin
        if (!rst_i)
        begin
            if (lookup_valid_o != req_hist[1])
            begin
                $display("lookup_valid_o did not follow a request by two cycles");
                n_fail++;
            end
            if (lookup_valid_o && exp_name.size() == 0)
            begin
                $display("lookup result arrived with no request pending");
                n_fail++;
            end
            else if (lookup_valid_o)
            begin
                mon_name  = exp_name.pop_front();
                mon_width = exp_width.pop_front();
                mon_value = exp_value.pop_front();
                if (lookup_width_o != 5'(mon_width) || lookup_value_o != 8'(mon_value))
                begin
                    $display("[FAIL] %s expected width %0d value 0x%02h actual %0d 0x%02h",
                             mon_name, mon_width, mon_value, lookup_width_o, lookup_value_o);
                    n_fail++;
                end
                else
                begin
                    $display("[PASS] %s", mon_name);
                    n_pass++;
                end
            end
        end
        req_hist = {req_hist[0], lookup_req_i};
    end

    initial
    begin
        rst_i          = 1'b1;
        cfg_valid_i    = 1'b0;
        cfg_data_i     = '0;
        cfg_last_i     = 1'b0;
        lookup_req_i   = 1'b0;
        lookup_table_i = '0;
        lookup_input_i = '0;
        build_segments();
        build_rows();
        built = 1'b1;
        repeat (5) @(posedge clk_i);
        rst_i <= 1'b0;
        @(negedge clk_i);
        check_value("reset_accept_high", 1, int'(cfg_accept_o));
        check_value("reset_valid_low", 0, int'(lookup_valid_o));

        for (int seg = 0; seg < NUM_SEG; seg++)
        begin
            @(posedge clk_i);
            stalls = 0;
            for (int i = 0; i < stim_byte.size(); i++)
            begin
                if (stim_seg[i] == seg)
                    send_byte(stim_byte[i], stim_last[i]);
            end
            cfg_valid_i <= 1'b0;
            cfg_last_i  <= 1'b0;
            if (seg == 0)
                check_value("gap_load_accept_low", 1, int'(stalls != 0));

            // Lookups back to back, one per cycle
            for (int i = 0; i < row_name.size(); i++)
            begin
                if (row_seg[i] == seg)
                begin
                    lookup_req_i   <= 1'b1;
                    lookup_table_i <= 2'(row_tbl[i]);
                    lookup_input_i <= 16'(row_win[i]);
                    exp_name.push_back(row_name[i]);
                    exp_width.push_back(row_width[i]);
                    exp_value.push_back(row_value[i]);
                    @(posedge clk_i);
                end
            end
            lookup_req_i <= 1'b0;
            while (exp_name.size() != 0)
                @(negedge clk_i);
        end

        repeat (3) @(negedge clk_i);
        $display("Tests: %0d passed, %0d failed", n_pass, n_fail);
        if (n_fail == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

    // Three clock periods per byte and per lookup, plus slack
    initial
    begin
        wait (built);
        limit = (stim_byte.size() + row_name.size() + 20) * 3 * CLK_PERIOD;
        #(limit);
        $display("Watchdog expired before all tests finished");
        $display("TEST FAILED");
        $finish;
    end

endmodule

//--- verif/jpeg_dht_sva.sv
// Concurrent assertions on lookup latency and loader handshake, bound into the DHT top level
`timescale 1ns/100ps

module jpeg_dht_sva (
    input logic                         clk_i,
    input logic                         rst_i,
    input logic                         cfg_valid_i,
    input logic                         cfg_last_i,
    input logic                         cfg_accept_o,
    input logic                         lookup_req_i,
    input logic                         lookup_valid_o,
    input jpeg_huff_pkg::dht_state_e    state_i
);

    // Two-stage pipeline, fixed latency
    valid_latency_a: assert property (@(posedge clk_i) disable iff (rst_i)
        lookup_valid_o == $past(lookup_req_i, 2))
        else $error("lookup_valid_o is not lookup_req_i delayed by two cycles");

    last_ends_table_a: assert property (@(posedge clk_i) disable iff (rst_i)
        cfg_valid_i && cfg_accept_o && cfg_last_i |=> state_i == jpeg_huff_pkg::ST_ID)
        else $error("loader left ST_ID after a byte marked last");

    // An ID byte opens the count bytes, which are taken without a stall
    id_opens_counts_a: assert property (@(posedge clk_i) disable iff (rst_i)
        state_i == jpeg_huff_pkg::ST_ID && cfg_valid_i && cfg_accept_o && !cfg_last_i
        |=> state_i == jpeg_huff_pkg::ST_COUNTS && cfg_accept_o)
        else $error("count bytes not accepted after a table ID byte");

endmodule

bind jpeg_dht jpeg_dht_sva jpeg_dht_sva_inst (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .cfg_valid_i    (cfg_valid_i),
    .cfg_last_i     (cfg_last_i),
    .cfg_accept_o   (cfg_accept_o),
    .lookup_req_i   (lookup_req_i),
    .lookup_valid_o (lookup_valid_o),
    .state_i        (u_parser.state_q)
);

//--- src/jpeg_dht.sv
// Top level of the DHT table loader and Huffman lookup, connects parser, store and lookup
`timescale 1ns/100ps

module jpeg_dht (
    input  logic        clk_i,
    input  logic        rst_i,
    // Segment bytes, valid/accept
    input  logic        cfg_valid_i,
    input  logic [7:0]  cfg_data_i,
    input  logic        cfg_last_i,
    output logic        cfg_accept_o,
    // Lookup, result two cycles after request
    input  logic        lookup_req_i,
    input  logic [1:0]  lookup_table_i,
    input  logic [15:0] lookup_input_i,
    output logic        lookup_valid_o,
    output logic [4:0]  lookup_width_o,
    output logic [7:0]  lookup_value_o
);

    dht_wr_if wr_if ();
    dht_rd_if rd_if ();

    dht_parser u_parser (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .cfg_valid_i  (cfg_valid_i),
        .cfg_data_i   (cfg_data_i),
        .cfg_last_i   (cfg_last_i),
        .cfg_accept_o (cfg_accept_o),
        .wr           (wr_if.tx)
    );

    dht_table_store u_store (
        .clk_i (clk_i),
        .rst_i (rst_i),
        .wr    (wr_if.rx),
        .rd    (rd_if.rsp)
    );

    dht_lookup u_lookup (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .lookup_req_i   (lookup_req_i),
        .lookup_table_i (lookup_table_i),
        .lookup_input_i (lookup_input_i),
        .lookup_valid_o (lookup_valid_o),
        .lookup_width_o (lookup_width_o),
        .lookup_value_o (lookup_value_o),
        .rd             (rd_if.req)
    );

endmodule

//--- src/dht_lookup.sv
// Two-stage Huffman lookup pipeline that returns code width and symbol for a 16-bit window
`timescale 1ns/100ps

module dht_lookup (
    input  logic                                clk_i,
    input  logic                                rst_i,
    input  logic                                lookup_req_i,
    input  logic [1:0]                          lookup_table_i,
    input  logic [jpeg_huff_pkg::CODE_W-1:0]    lookup_input_i,
    output logic                                lookup_valid_o,
    output logic [jpeg_huff_pkg::LEN_IDX_W:0]   lookup_width_o,
    output logic [jpeg_huff_pkg::SYM_W-1:0]     lookup_value_o,
    dht_rd_if.req                               rd
);

    jpeg_huff_pkg::huff_tbl_e               tbl_w;
    jpeg_huff_pkg::huff_tbl_e               tbl_q;
    logic [jpeg_huff_pkg::LEN_IDX_W-1:0]    len_w;
    logic [jpeg_huff_pkg::LEN_IDX_W-1:0]    len_q;
    logic [jpeg_huff_pkg::CODE_W-1:0]       win_q;
    logic                                   vld1_q;
    logic [jpeg_huff_pkg::CODE_W-1:0]       code_w;
    logic [jpeg_huff_pkg::CODE_W-1:0]       addr_w;
    logic [jpeg_huff_pkg::LEN_IDX_W:0]      width_q;
    logic                                   vld2_q;

    // ----------------------------------------
    // Stage 1, match shortest code length
    // ----------------------------------------
    assign tbl_w     = jpeg_huff_pkg::huff_tbl_e'(lookup_table_i);
    assign rd.rd_tbl = tbl_w;

    // Scan from long to short so the shortest match wins
    always_comb
    begin
        len_w = jpeg_huff_pkg::LEN_IDX_W'(jpeg_huff_pkg::NUM_LEN - 1);
        for (int l = jpeg_huff_pkg::NUM_LEN - 2; l >= 0; l--)
        begin
            if ((lookup_input_i >> (jpeg_huff_pkg::CODE_W - 1 - l)) < rd.max_codes[l])
                len_w = jpeg_huff_pkg::LEN_IDX_W'(l);
        end
    end

    always_ff @(posedge clk_i)
    begin
        len_q <= len_w;
        tbl_q <= tbl_w;
        win_q <= lookup_input_i;
    end

    // ----------------------------------------
    // Stage 2, symbol RAM address
    // ----------------------------------------
    assign rd.rd_tbl2 = tbl_q;
    assign rd.rd_len  = len_q;

    // Top L+1 bits of the window, offset into this length's symbols
    assign code_w = win_q >> (jpeg_huff_pkg::LEN_IDX_W'(jpeg_huff_pkg::CODE_W - 1) - len_q);
    assign addr_w = code_w - rd.rd_min + jpeg_huff_pkg::CODE_W'(rd.rd_ptr);
    assign rd.sym_raddr = addr_w[jpeg_huff_pkg::PTR_W-1:0];

    always_ff @(posedge clk_i)
    begin
        width_q <= {1'b0, len_q} + 1'b1;
    end

    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            vld1_q <= 1'b0;
            vld2_q <= 1'b0;
        end
        else
        begin
            vld1_q <= lookup_req_i;
            vld2_q <= vld1_q;
        end
    end

    assign lookup_valid_o = vld2_q;
    assign lookup_width_o = width_q;
    assign lookup_value_o = rd.sym_rdata;

endmodule

//--- src/dht_table_store.sv
// Holds per-table canonical code bounds and the shared symbol RAM for Huffman lookups
`timescale 1ns/100ps

module dht_table_store (
    input  logic    clk_i,
    input  logic    rst_i,
    dht_wr_if.rx    wr,
    dht_rd_if.rsp   rd
);

    logic [jpeg_huff_pkg::CODE_W-1:0]
        min_q [jpeg_huff_pkg::NUM_TBL][jpeg_huff_pkg::NUM_LEN];
    logic [jpeg_huff_pkg::CODE_W-1:0]
        max_q [jpeg_huff_pkg::NUM_TBL][jpeg_huff_pkg::NUM_LEN];
    logic [jpeg_huff_pkg::PTR_W-1:0]
        ptr_q [jpeg_huff_pkg::NUM_TBL][jpeg_huff_pkg::NUM_LEN];
    logic [jpeg_huff_pkg::SYM_W-1:0] sym_ram [jpeg_huff_pkg::SYM_DEPTH];
    logic [jpeg_huff_pkg::SYM_W-1:0] sym_rdata_q;

    // ----------------------------------------
    // Code bound arrays
    // ----------------------------------------

    // Zero max means an empty length never matches
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            for (int t = 0; t < jpeg_huff_pkg::NUM_TBL; t++)
            begin
                for (int l = 0; l < jpeg_huff_pkg::NUM_LEN; l++)
                begin
                    min_q[t][l] <= '0;
                    max_q[t][l] <= '0;
                    ptr_q[t][l] <= '0;
                end
            end
        end
        else if (wr.bound_we)
        begin
            min_q[wr.tbl][wr.len_idx] <= wr.min_code;
            max_q[wr.tbl][wr.len_idx] <= wr.max_code;
            ptr_q[wr.tbl][wr.len_idx] <= wr.base_ptr;
        end
    end

    // Stage 1 sees every bound of the requested table
    always_comb
    begin
        for (int l = 0; l < jpeg_huff_pkg::NUM_LEN; l++)
            rd.max_codes[l] = max_q[rd.rd_tbl][l];
    end

    assign rd.rd_min = min_q[rd.rd_tbl2][rd.rd_len];
    assign rd.rd_ptr = ptr_q[rd.rd_tbl2][rd.rd_len];

    // ----------------------------------------
    // Symbol RAM
    // ----------------------------------------
    always_ff @(posedge clk_i)
    begin
        if (wr.sym_we)
            sym_ram[wr.sym_addr] <= wr.sym_data;
        sym_rdata_q <= sym_ram[rd.sym_raddr];
    end

    assign rd.sym_rdata = sym_rdata_q;

endmodule

//--- src/dht_parser.sv
// Walks DHT segment bytes and issues canonical code bounds and symbol writes to the table store
`timescale 1ns/100ps

module dht_parser (
    input  logic                            clk_i,
    input  logic                            rst_i,
    input  logic                            cfg_valid_i,
    input  logic [jpeg_huff_pkg::SYM_W-1:0] cfg_data_i,
    input  logic                            cfg_last_i,
    output logic                            cfg_accept_o,
    dht_wr_if.tx                            wr
);

    jpeg_huff_pkg::dht_state_e              state_q;
    jpeg_huff_pkg::huff_tbl_e               tbl_q;
    jpeg_huff_pkg::huff_tbl_e               id_tbl_w;
    logic [jpeg_huff_pkg::LEN_IDX_W-1:0]    idx_q;
    logic [jpeg_huff_pkg::SYM_W-1:0]        counts_q [jpeg_huff_pkg::NUM_LEN];
    logic [jpeg_huff_pkg::NUM_LEN-1:0]      has_q;
    logic [jpeg_huff_pkg::CNT_W-1:0]        total_q;
    logic [jpeg_huff_pkg::CNT_W-1:0]        total_next_w;
    logic [jpeg_huff_pkg::CNT_W-1:0]        taken_q;
    logic [jpeg_huff_pkg::LEN_IDX_W-1:0]    len_q;
    logic [jpeg_huff_pkg::SYM_W-1:0]        in_len_q;
    logic [jpeg_huff_pkg::CODE_W-1:0]       code_q;
    logic [jpeg_huff_pkg::PTR_W-1:0]        ptr_q;
    logic                                   accept_w;
    logic                                   sym_w;
    logic                                   end_w;
    logic                                   last_of_len_w;

    // ----------------------------------------
    // Handshake and decode
    // ----------------------------------------

    // Stall only while stepping over an empty length
    assign cfg_accept_o  = (state_q != jpeg_huff_pkg::ST_SYMBOLS) || has_q[len_q];
    assign accept_w      = cfg_valid_i && cfg_accept_o;
    assign sym_w         = accept_w && (state_q == jpeg_huff_pkg::ST_SYMBOLS);
    assign total_next_w  = total_q + jpeg_huff_pkg::CNT_W'(cfg_data_i);
    assign last_of_len_w = (in_len_q + 1'b1) == counts_q[len_q];
    // Table closes on cfg_last_i or on its final symbol
    assign end_w         = cfg_last_i || ((taken_q + 1'b1) == total_q);

    always_comb
    begin
        case (cfg_data_i)
            jpeg_huff_pkg::DHT_ID_Y_DC:  id_tbl_w = jpeg_huff_pkg::TBL_Y_DC;
            jpeg_huff_pkg::DHT_ID_Y_AC:  id_tbl_w = jpeg_huff_pkg::TBL_Y_AC;
            jpeg_huff_pkg::DHT_ID_CX_DC: id_tbl_w = jpeg_huff_pkg::TBL_CX_DC;
            default:                     id_tbl_w = jpeg_huff_pkg::TBL_CX_AC;
        endcase
    end

    // Count bytes of the current table
    always_ff @(posedge clk_i)
    begin
        if (state_q == jpeg_huff_pkg::ST_COUNTS && accept_w)
            counts_q[idx_q] <= cfg_data_i;
    end

    // ----------------------------------------
    // Loader FSM and canonical code walk
    // ----------------------------------------
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            state_q  <= jpeg_huff_pkg::ST_ID;
            tbl_q    <= jpeg_huff_pkg::TBL_Y_DC;
            idx_q    <= '0;
            has_q    <= '0;
            total_q  <= '0;
            taken_q  <= '0;
            len_q    <= '0;
            in_len_q <= '0;
            code_q   <= '0;
            ptr_q    <= '0;
        end
        else
        begin
            case (state_q)
                jpeg_huff_pkg::ST_ID:
                    if (accept_w)
                    begin
                        tbl_q    <= id_tbl_w;
                        idx_q    <= '0;
                        has_q    <= '0;
                        total_q  <= '0;
                        taken_q  <= '0;
                        len_q    <= '0;
                        in_len_q <= '0;
                        code_q   <= '0;
                        if (!cfg_last_i)
                            state_q <= jpeg_huff_pkg::ST_COUNTS;
                    end
                jpeg_huff_pkg::ST_COUNTS:
                    if (accept_w)
                    begin
                        has_q[idx_q] <= (cfg_data_i != '0);
                        total_q      <= total_next_w;
                        idx_q        <= idx_q + 1'b1;
                        // A table with no codes has no symbol bytes
                        if (cfg_last_i || (&idx_q && total_next_w == '0))
                            state_q <= jpeg_huff_pkg::ST_ID;
                        else if (&idx_q)
                            state_q <= jpeg_huff_pkg::ST_SYMBOLS;
                    end
                jpeg_huff_pkg::ST_SYMBOLS:
                    if (!has_q[len_q])
                    begin
                        len_q  <= len_q + 1'b1;
                        code_q <= code_q << 1;
                    end
                    else if (accept_w)
                    begin
                        taken_q <= taken_q + 1'b1;
                        ptr_q   <= ptr_q + 1'b1;
                        if (last_of_len_w)
                        begin
                            in_len_q <= '0;
                            len_q    <= len_q + 1'b1;
                            code_q   <= (code_q + 1'b1) << 1;
                        end
                        else
                        begin
                            in_len_q <= in_len_q + 1'b1;
                            code_q   <= code_q + 1'b1;
                        end
                        if (end_w)
                            state_q <= jpeg_huff_pkg::ST_ID;
                    end
                default:
                    state_q <= jpeg_huff_pkg::ST_ID;
            endcase
        end
    end

    // ----------------------------------------
    // Store writes
    // ----------------------------------------

    // Bounds go out with the first symbol of each length
    assign wr.bound_we = sym_w && (in_len_q == '0);
    assign wr.tbl      = tbl_q;
    assign wr.len_idx  = len_q;
    assign wr.min_code = code_q;
    assign wr.max_code = code_q + jpeg_huff_pkg::CODE_W'(counts_q[len_q]);
    assign wr.base_ptr = ptr_q;
    assign wr.sym_we   = sym_w;
    assign wr.sym_addr = ptr_q;
    assign wr.sym_data = cfg_data_i;

endmodule

//--- src/dht_tbl_if.sv
// Write and read interfaces between the DHT parser, the table store and the lookup pipeline
`timescale 1ns/100ps

// Table writes from the parser, single-cycle strobes
interface dht_wr_if;
    // Code bounds for one (table, length) pair
    logic                                   bound_we;
    jpeg_huff_pkg::huff_tbl_e               tbl;
    logic [jpeg_huff_pkg::LEN_IDX_W-1:0]    len_idx;
    logic [jpeg_huff_pkg::CODE_W-1:0]       min_code;
    logic [jpeg_huff_pkg::CODE_W-1:0]       max_code;
    logic [jpeg_huff_pkg::PTR_W-1:0]        base_ptr;
    // Symbol RAM write
    logic                                   sym_we;
    logic [jpeg_huff_pkg::PTR_W-1:0]        sym_addr;
    logic [jpeg_huff_pkg::SYM_W-1:0]        sym_data;

    modport tx (output bound_we, tbl, len_idx, min_code, max_code, base_ptr,
                output sym_we, sym_addr, sym_data);
    modport rx (input  bound_we, tbl, len_idx, min_code, max_code, base_ptr,
                input  sym_we, sym_addr, sym_data);
endinterface

// Table reads for the two lookup stages
interface dht_rd_if;
    // Stage 1, all upper bounds of one table
    jpeg_huff_pkg::huff_tbl_e                                           rd_tbl;
    logic [jpeg_huff_pkg::NUM_LEN-1:0][jpeg_huff_pkg::CODE_W-1:0]       max_codes;
    // Stage 2, lower bound and pointer of the matched length
    jpeg_huff_pkg::huff_tbl_e                                           rd_tbl2;
    logic [jpeg_huff_pkg::LEN_IDX_W-1:0]                                rd_len;
    logic [jpeg_huff_pkg::CODE_W-1:0]                                   rd_min;
    logic [jpeg_huff_pkg::PTR_W-1:0]                                    rd_ptr;
    // Symbol RAM, data one cycle after address
    logic [jpeg_huff_pkg::PTR_W-1:0]                                    sym_raddr;
    logic [jpeg_huff_pkg::SYM_W-1:0]                                    sym_rdata;

    modport req (output rd_tbl, rd_tbl2, rd_len, sym_raddr,
                 input  max_codes, rd_min, rd_ptr, sym_rdata);
    modport rsp (input  rd_tbl, rd_tbl2, rd_len, sym_raddr,
                 output max_codes, rd_min, rd_ptr, sym_rdata);
endinterface

//--- src/jpeg_huff_pkg.sv
// Shared types, widths and DHT segment constants for the Huffman table loader and lookup
package jpeg_huff_pkg;

    // ----------------------------------------
    // Widths and sizes
    // ----------------------------------------

    // Code, code bound and bitstream window
    localparam int CODE_W    = 16;
    // Code lengths 1 to 16
    localparam int NUM_LEN   = 16;
    localparam int LEN_IDX_W = 4;
    // Luma DC, luma AC, chroma DC, chroma AC
    localparam int NUM_TBL   = 4;
    // Symbol RAM shared by all tables
    localparam int PTR_W     = 10;
    localparam int SYM_DEPTH = 1024;
    // Symbols and segment bytes are both one byte wide
    localparam int SYM_W     = 8;
    // Sum of the 16 counts of one table
    localparam int CNT_W     = 12;

    // ----------------------------------------
    // Table-ID bytes in the segment
    // ----------------------------------------

    // Any other ID byte selects the chroma AC table
    localparam logic [7:0] DHT_ID_Y_DC  = 8'h00;
    localparam logic [7:0] DHT_ID_Y_AC  = 8'h10;
    localparam logic [7:0] DHT_ID_CX_DC = 8'h01;

    // Lookup request encodes these as 0 to 3
    typedef enum logic [1:0] {
        TBL_Y_DC  = 2'd0,
        TBL_Y_AC  = 2'd1,
        TBL_CX_DC = 2'd2,
        TBL_CX_AC = 2'd3
    } huff_tbl_e;

    // Loader walks ID byte, then 16 counts, then symbols
    typedef enum logic [1:0] {
        ST_ID,
        ST_COUNTS,
        ST_SYMBOLS
    } dht_state_e;

endpackage
